// File: mem_pkg.sv
// Memory side definitions
// Cache-line geometry in edges and bytes
// Slot, count, address and line types
// Read command record and command queue depth

package mem_pkg;

	////////////////////
	// Line geometry
	////////////////////

	localparam int line_edges = 8;
	localparam int edge_bytes = 4;
	localparam int line_bytes = line_edges * edge_bytes;

	// Queue of read commands waiting for a grant
	localparam int cmd_fifo_depth = 4;

	typedef logic [$clog2(line_edges)-1:0] slot_t;
	typedef logic [$clog2(line_edges):0]   count_t;
	typedef logic [31:0]                   addr_t;
	typedef logic [line_bytes*8-1:0]       line_t;

	////////////////////
	// Read command
	////////////////////

	// Offset is the first useful slot of the returned line
	typedef struct packed {
		addr_t  address;
		count_t count;
		slot_t  offset;
	} read_cmd_t;

endpackage

// File: graph_pkg.sv
// Graph side definitions
// Vertex and edge field widths
// Edge job record and edge job queue depth

package graph_pkg;

	////////////////////
	// Field widths
	////////////////////

	typedef logic [15:0] vertex_id_t;
	typedef logic [23:0] edge_idx_t;
	typedef logic [15:0] degree_t;
	typedef logic [31:0] edge_dest_t;

	////////////////////
	// Edge job
	////////////////////

	// Id counts edges within one vertex, from 0
	typedef struct packed {
		vertex_id_t src;
		edge_dest_t dest;
		degree_t    id;
	} edge_job_t;

	// Queue in front of the edge consumer
	localparam int edge_fifo_depth = 16;

endpackage

// File: edge_chunk_if.sv
// Chunk of one cache-line read
// Plan strobe, planned address, count and first slot
// Remaining edge level for the current vertex

`timescale 1ns/10ps

interface edge_chunk_if;

	logic               plan;
	logic               chunk_valid;
	mem_pkg::addr_t     chunk_address;
	mem_pkg::count_t    chunk_count;
	mem_pkg::slot_t     chunk_offset;
	logic               remaining_zero;

	// Planner side
	modport counter (input plan, output chunk_valid, chunk_address, chunk_count,
		chunk_offset, remaining_zero);

	// Sequencer side
	modport fsm (output plan, input chunk_valid, remaining_zero);

	// Line shifter keeps count and offset of the read in flight
	modport shifter (input chunk_valid, chunk_count, chunk_offset, remaining_zero);

endinterface

// File: job_fifo.sv
// Synchronous FIFO with a typed payload
// Circular buffer, registered read port and fill count
// Checks for overflow and underflow

`timescale 1ns/10ps

module job_fifo #(
	parameter type payload_t = mem_pkg::read_cmd_t,
	parameter int  depth     = mem_pkg::cmd_fifo_depth
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  payload_t                     data_in,
	input  logic                         pop,
	output payload_t                     data_out,
	output logic                         out_valid,
	output logic                         empty,
	output logic [$clog2(depth+1)-1:0]   count
);

	payload_t                   mem [depth];
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic                       full;

	assign empty = (count == '0);
	assign full  = (count == ($clog2(depth+1))'(depth));

	// Pointers and fill level
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
			if (push)
				wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
		end
	end

	// Storage and output register
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
		if (pop)
			data_out <= mem[rd_ptr];
	end

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

// File: edge_burst_counter.sv
// Edge burst counter
// Next edge index, remaining edges and base address of a vertex
// Plans one cache-line chunk per plan strobe

`timescale 1ns/10ps

module edge_burst_counter (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    load,
	input  graph_pkg::edge_idx_t    edges_idx,
	input  graph_pkg::degree_t      degree,
	input  mem_pkg::addr_t          edges_base,
	edge_chunk_if.counter           chunk
);

	graph_pkg::edge_idx_t   next_idx;
	graph_pkg::degree_t     remaining;
	mem_pkg::addr_t         base;
	mem_pkg::slot_t         first_slot;
	mem_pkg::count_t        room;
	mem_pkg::count_t        take;
	mem_pkg::addr_t         byte_offset;

	////////////////////
	// Chunk rule
	////////////////////

	assign first_slot  = next_idx[$bits(mem_pkg::slot_t)-1:0];
	assign room        = mem_pkg::count_t'(mem_pkg::line_edges) - mem_pkg::count_t'(first_slot);
	assign take        = (remaining < graph_pkg::degree_t'(room)) ?
		mem_pkg::count_t'(remaining) : room;
	assign byte_offset = mem_pkg::addr_t'(next_idx) * mem_pkg::addr_t'(mem_pkg::edge_bytes);

	assign chunk.remaining_zero = (remaining == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_idx          <= '0;
			remaining         <= '0;
			chunk.chunk_valid <= 1'b0;
		end else begin
			chunk.chunk_valid <= chunk.plan;
			if (load) begin
				next_idx  <= edges_idx;
				remaining <= degree;
			end else if (chunk.plan) begin
				next_idx  <= next_idx + graph_pkg::edge_idx_t'(take);
				remaining <= remaining - graph_pkg::degree_t'(take);
			end
		end
	end

	// Chunk fields hold until the next plan
	always_ff @(posedge clock) begin
		if (load)
			base <= edges_base;
		if (chunk.plan) begin
			chunk.chunk_address <= base +
				(byte_offset & ~mem_pkg::addr_t'(mem_pkg::line_bytes - 1));
			chunk.chunk_count   <= take;
			chunk.chunk_offset  <= first_slot;
		end
	end

	// Sequencer must stop planning once the vertex is used up
	assert property (@(posedge clock) disable iff (!rstn) chunk.plan |-> !chunk.remaining_zero);

endmodule

// File: edge_line_shifter.sv
// Edge line shifter
// Keeps count and offset of the read in flight
// Loads the returned line pre-shifted to the first slot
// Slot timer emits one edge job per cycle

`timescale 1ns/10ps

module edge_line_shifter (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    read_data_valid,
	input  mem_pkg::line_t          read_data,
	input  graph_pkg::vertex_id_t   vertex_id,
	edge_chunk_if.shifter           chunk,
	output logic                    edge_push,
	output graph_pkg::edge_job_t    edge_job,
	output logic                    shift_done
);

	mem_pkg::count_t        count_q;
	mem_pkg::slot_t         offset_q;
	mem_pkg::line_t         line_q;
	mem_pkg::count_t        slots_left;
	graph_pkg::degree_t     edge_id;

	// Timer running means an edge sits in slot 0
	assign edge_push  = (slots_left != '0);
	assign shift_done = (slots_left == mem_pkg::count_t'(1));

	assign edge_job.src  = vertex_id;
	assign edge_job.dest = line_q[$bits(graph_pkg::edge_dest_t)-1:0];
	assign edge_job.id   = edge_id;

	////////////////////
	// Line datapath
	////////////////////

	always_ff @(posedge clock) begin
		if (chunk.chunk_valid) begin
			count_q  <= chunk.chunk_count;
			offset_q <= chunk.chunk_offset;
		end
		if (read_data_valid)
			line_q <= read_data >> (int'(offset_q) * $bits(graph_pkg::edge_dest_t));
		else if (edge_push)
			line_q <= line_q >> $bits(graph_pkg::edge_dest_t);
	end

	////////////////////
	// Slot timer
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slots_left <= '0;
			edge_id    <= '0;
		end else begin
			if (read_data_valid)
				slots_left <= count_q;
			else if (edge_push)
				slots_left <= slots_left - 1'b1;

			// Id restarts once the last edge of a vertex is out
			if (shift_done && chunk.remaining_zero)
				edge_id <= '0;
			else if (edge_push)
				edge_id <= edge_id + 1'b1;
		end
	end

	// Only one read in flight, so no line may arrive mid-shift
	assert property (@(posedge clock) disable iff (!rstn) read_data_valid |-> !edge_push);

endmodule

// File: edge_job_fsm.sv
// Edge job sequencer FSM
// Vertex intake and ready level
// Chunk planning under command and edge queue back-pressure
// Command push, data wait and shift completion

`timescale 1ns/10ps

module edge_job_fsm (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    vertex_valid,
	output logic                    vertex_ready,
	edge_chunk_if.fsm               chunk,
	input  logic                    cmd_empty,
	input  logic [$clog2(graph_pkg::edge_fifo_depth+1)-1:0] edge_count,
	input  logic                    shift_done,
	output logic                    cmd_push
);

	typedef enum logic [2:0] {
		st_idle,
		st_plan,
		st_issue,
		st_wait_data,
		st_next
	} state_t;

	state_t     state;
	state_t     state_next;
	logic       room_ok;

	assign vertex_ready = (state == st_idle);

	// A whole line of edges must fit in the edge queue
	assign room_ok = cmd_empty &&
		(int'(edge_count) <= graph_pkg::edge_fifo_depth - mem_pkg::line_edges);

	assign chunk.plan = (state == st_plan) && room_ok;

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (vertex_valid)
					state_next = st_plan;
			end
			st_plan: begin
				if (room_ok)
					state_next = st_issue;
			end
			st_issue: begin
				if (chunk.chunk_valid)
					state_next = st_wait_data;
			end
			st_wait_data: begin
				if (shift_done)
					state_next = chunk.remaining_zero ? st_idle : st_next;
			end
			st_next: begin
				// Lets the edge queue count settle before the next plan
				state_next = st_plan;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= st_idle;
			cmd_push <= 1'b0;
		end else begin
			state    <= state_next;
			cmd_push <= chunk.chunk_valid;
		end
	end

endmodule

// File: edge_job_control.sv
// Edge job generator top level
// Vertex register, command and edge job queues
// Sequencer, chunk planner and line shifter instances

`timescale 1ns/10ps

module edge_job_control (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    vertex_valid,
	output logic                    vertex_ready,
	input  graph_pkg::vertex_id_t   vertex_id,
	input  graph_pkg::edge_idx_t    vertex_edges_idx,
	input  graph_pkg::degree_t      vertex_degree,
	input  mem_pkg::addr_t          edges_base,
	output logic                    read_request,
	input  logic                    read_grant,
	output logic                    read_cmd_valid,
	output mem_pkg::addr_t          read_cmd_address,
	output mem_pkg::count_t         read_cmd_count,
	output mem_pkg::slot_t          read_cmd_offset,
	input  logic                    read_data_valid,
	input  mem_pkg::line_t          read_data,
	input  logic                    edge_request,
	output logic                    edge_empty,
	output logic                    edge_valid,
	output graph_pkg::vertex_id_t   edge_src,
	output graph_pkg::edge_dest_t   edge_dest,
	output graph_pkg::degree_t      edge_id
);

	logic                   vertex_accept;
	graph_pkg::vertex_id_t  vertex_id_q;
	logic                   cmd_push;
	logic                   cmd_empty;
	mem_pkg::read_cmd_t     cmd_in;
	mem_pkg::read_cmd_t     cmd_out;
	logic                   edge_push;
	logic                   shift_done;
	graph_pkg::edge_job_t   edge_job_in;
	graph_pkg::edge_job_t   edge_job_out;
	logic [$clog2(graph_pkg::edge_fifo_depth+1)-1:0] edge_count;

	edge_chunk_if chunk ();

	assign vertex_accept = vertex_valid && vertex_ready;

	// Source id for every edge of the current vertex
	always_ff @(posedge clock) begin
		if (vertex_accept)
			vertex_id_q <= vertex_id;
	end

	edge_job_fsm i_fsm (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_valid (vertex_valid),
		.vertex_ready (vertex_ready),
		.chunk        (chunk.fsm),
		.cmd_empty    (cmd_empty),
		.edge_count   (edge_count),
		.shift_done   (shift_done),
		.cmd_push     (cmd_push)
	);

	edge_burst_counter i_counter (
		.clock      (clock),
		.rstn       (rstn),
		.load       (vertex_accept),
		.edges_idx  (vertex_edges_idx),
		.degree     (vertex_degree),
		.edges_base (edges_base),
		.chunk      (chunk.counter)
	);

	edge_line_shifter i_shifter (
		.clock           (clock),
		.rstn            (rstn),
		.read_data_valid (read_data_valid),
		.read_data       (read_data),
		.vertex_id       (vertex_id_q),
		.chunk           (chunk.shifter),
		.edge_push       (edge_push),
		.edge_job        (edge_job_in),
		.shift_done      (shift_done)
	);

	////////////////////
	// Command queue
	////////////////////

	assign cmd_in = '{address: chunk.chunk_address, count: chunk.chunk_count,
		offset: chunk.chunk_offset};

	job_fifo #(
		.payload_t (mem_pkg::read_cmd_t),
		.depth     (mem_pkg::cmd_fifo_depth)
	) cmd_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (cmd_push),
		.data_in   (cmd_in),
		.pop       (read_grant),
		.data_out  (cmd_out),
		.out_valid (read_cmd_valid),
		.empty     (cmd_empty),
		.count     ()
	);

	assign read_request     = !cmd_empty;
	assign read_cmd_address = cmd_out.address;
	assign read_cmd_count   = cmd_out.count;
	assign read_cmd_offset  = cmd_out.offset;

	////////////////////
	// Edge job queue
	////////////////////

	job_fifo #(
		.payload_t (graph_pkg::edge_job_t),
		.depth     (graph_pkg::edge_fifo_depth)
	) edge_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (edge_push),
		.data_in   (edge_job_in),
		.pop       (edge_request),
		.data_out  (edge_job_out),
		.out_valid (edge_valid),
		.empty     (edge_empty),
		.count     (edge_count)
	);

	assign edge_src  = edge_job_out.src;
	assign edge_dest = edge_job_out.dest;
	assign edge_id   = edge_job_out.id;

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
// 100 ns clock, active low reset held for the first 10 cycles

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	localparam int half_period = 50;
	localparam int release_delay = 5;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// Release a little after the tenth rising edge
	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge clock);
		#release_delay;
		rstn = 1'b1;
	end

endmodule

// File: tb_edge_job_control.sv
// Testbench for the edge job generator
// Vertex stimulus, grant driver, memory model and edge consumer
// Scoreboard of predicted read commands and edge jobs
// Protocol checks by concurrent assertions, values by immediate ones

`timescale 1ns/10ps

module tb_edge_job_control;

	localparam int drive_delay = 10;
	localparam int wait_limit  = 3000;

	logic                   clock;
	logic                   rstn;
	logic                   vertex_valid;
	logic                   vertex_ready;
	graph_pkg::vertex_id_t  vertex_id;
	graph_pkg::edge_idx_t   vertex_edges_idx;
	graph_pkg::degree_t     vertex_degree;
	mem_pkg::addr_t         edges_base;
	logic                   read_request;
	logic                   read_grant;
	logic                   read_cmd_valid;
	mem_pkg::addr_t         read_cmd_address;
	mem_pkg::count_t        read_cmd_count;
	mem_pkg::slot_t         read_cmd_offset;
	logic                   read_data_valid;
	mem_pkg::line_t         read_data;
	logic                   edge_request;
	logic                   edge_empty;
	logic                   edge_valid;
	graph_pkg::vertex_id_t  edge_src;
	graph_pkg::edge_dest_t  edge_dest;
	graph_pkg::degree_t     edge_id;

	integer                 seed = 32'h50b1_d39b;
	string                  test_name = "reset";
	logic                   consume_enable = 1'b0;
	int                     cmds_seen = 0;
	mem_pkg::addr_t         cur_base = '0;
	mem_pkg::read_cmd_t     cmd_q[$];
	graph_pkg::edge_job_t   edge_q[$];
	mem_pkg::read_cmd_t     expected_cmd;
	graph_pkg::edge_job_t   expected_job;

	tb_clock_gen i_clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	edge_job_control i_dut (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_valid     (vertex_valid),
		.vertex_ready     (vertex_ready),
		.vertex_id        (vertex_id),
		.vertex_edges_idx (vertex_edges_idx),
		.vertex_degree    (vertex_degree),
		.edges_base       (edges_base),
		.read_request     (read_request),
		.read_grant       (read_grant),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_address (read_cmd_address),
		.read_cmd_count   (read_cmd_count),
		.read_cmd_offset  (read_cmd_offset),
		.read_data_valid  (read_data_valid),
		.read_data        (read_data),
		.edge_request     (edge_request),
		.edge_empty       (edge_empty),
		.edge_valid       (edge_valid),
		.edge_src         (edge_src),
		.edge_dest        (edge_dest),
		.edge_id          (edge_id)
	);

	////////////////////
	// Checking
	////////////////////

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic expect_equal(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	assert property (@(posedge clock) disable iff (!rstn) read_cmd_valid == $past(read_grant))
		else begin
			$display("ERROR %s: read_cmd_valid did not follow read_grant by one cycle", test_name);
			abort_run();
		end

	assert property (@(posedge clock) disable iff (!rstn) edge_valid == $past(edge_request))
		else begin
			$display("ERROR %s: edge_valid did not follow edge_request by one cycle", test_name);
			abort_run();
		end

	assert property (@(posedge clock) disable iff (!rstn)
		!($past(vertex_valid && vertex_ready) && vertex_ready))
		else begin
			$display("ERROR %s: vertex_ready stayed high after a vertex was taken", test_name);
			abort_run();
		end

	////////////////////
	// Scoreboard
	////////////////////

	// Memory content of edge index n
	function automatic graph_pkg::edge_dest_t dest_of(input logic [31:0] n);
		return n ^ 32'h0000_a5a5;
	endfunction

	function automatic mem_pkg::line_t line_from_memory(input mem_pkg::addr_t address,
		input mem_pkg::addr_t base);
		mem_pkg::line_t line;
		logic [31:0]    first;
		line  = '0;
		first = (address - base) / mem_pkg::edge_bytes;
		for (int s = 0; s < mem_pkg::line_edges; s++)
			line[s*32 +: 32] = dest_of(first + s);
		return line;
	endfunction

	// Split a vertex into line reads and list its edges in order
	task automatic predict_vertex(input graph_pkg::vertex_id_t vid,
		input graph_pkg::edge_idx_t idx, input graph_pkg::degree_t degree,
		input mem_pkg::addr_t base);
		logic [31:0]          edge_index;
		int                   remaining;
		int                   slot;
		int                   take;
		int                   id;
		mem_pkg::read_cmd_t   cmd;
		graph_pkg::edge_job_t job;
		edge_index = idx;
		remaining  = degree;
		id         = 0;
		while (remaining > 0) begin
			slot = edge_index % mem_pkg::line_edges;
			take = mem_pkg::line_edges - slot;
			if (remaining < take)
				take = remaining;
			cmd.address = base + (edge_index * mem_pkg::edge_bytes) / mem_pkg::line_bytes
				* mem_pkg::line_bytes;
			cmd.count   = mem_pkg::count_t'(take);
			cmd.offset  = mem_pkg::slot_t'(slot);
			cmd_q.push_back(cmd);
			for (int k = 0; k < take; k++) begin
				job.src  = vid;
				job.dest = dest_of(edge_index + k);
				job.id   = graph_pkg::degree_t'(id);
				edge_q.push_back(job);
				id++;
			end
			edge_index += take;
			remaining  -= take;
		end
	endtask

	////////////////////
	// Environment
	////////////////////

	// Grant with random gaps while a command waits
	initial begin : grant_driver
		read_grant = 1'b0;
		forever begin
			@(posedge clock);
			#drive_delay;
			read_grant = rstn && read_request && ({$random(seed)} % 3 != 0);
		end
	end

	// Consumer pops with random gaps unless stalled
	initial begin : edge_consumer
		edge_request = 1'b0;
		forever begin
			@(posedge clock);
			#drive_delay;
			edge_request = rstn && consume_enable && !edge_empty && ({$random(seed)} % 2 == 0);
		end
	end

	initial begin : memory_model
		int             latency;
		mem_pkg::addr_t address;
		read_data_valid = 1'b0;
		read_data       = '0;
		forever begin
			@(posedge clock);
			#drive_delay;
			if (rstn && read_cmd_valid) begin
				if (cmd_q.size() == 0) begin
					$display("ERROR %s: read command when none was expected", test_name);
					abort_run();
				end
				expected_cmd = cmd_q.pop_front();
				expect_equal("read_cmd_address", expected_cmd.address, read_cmd_address);
				expect_equal("read_cmd_count", expected_cmd.count, read_cmd_count);
				expect_equal("read_cmd_offset", expected_cmd.offset, read_cmd_offset);
				address = read_cmd_address;
				latency = 2 + {$random(seed)} % 5;
				repeat (latency) @(posedge clock);
				#drive_delay;
				read_data       = line_from_memory(address, cur_base);
				read_data_valid = 1'b1;
				@(posedge clock);
				#drive_delay;
				read_data_valid = 1'b0;
			end
		end
	end

	// Count every command pulse, also one that comes while a read is outstanding
	always @(negedge clock) begin
		if (rstn && read_cmd_valid)
			cmds_seen++;
	end

	always @(negedge clock) begin
		if (rstn && edge_valid) begin
			if (edge_q.size() == 0) begin
				$display("ERROR %s: edge job when none was expected", test_name);
				abort_run();
			end
			expected_job = edge_q.pop_front();
			expect_equal("edge_src", expected_job.src, edge_src);
			expect_equal("edge_dest", expected_job.dest, edge_dest);
			expect_equal("edge_id", expected_job.id, edge_id);
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!vertex_ready) begin
			@(posedge clock);
			#drive_delay;
			cycles++;
			if (cycles > wait_limit) begin
				$display("ERROR %s: timeout waiting for vertex_ready", test_name);
				abort_run();
			end
		end
	endtask

	task automatic wait_commands(input int target);
		int cycles;
		cycles = 0;
		while (cmds_seen < target) begin
			@(posedge clock);
			#drive_delay;
			cycles++;
			if (cycles > wait_limit) begin
				$display("ERROR %s: timeout waiting for read commands", test_name);
				abort_run();
			end
		end
	endtask

	// Everything predicted has come out and the queue is empty
	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (cmd_q.size() != 0 || edge_q.size() != 0 || !vertex_ready || !edge_empty) begin
			@(posedge clock);
			#drive_delay;
			cycles++;
			if (cycles > wait_limit) begin
				$display("ERROR %s: timeout waiting for all edges to drain", test_name);
				abort_run();
			end
		end
	endtask

	task automatic run_vertex(input graph_pkg::vertex_id_t vid,
		input graph_pkg::edge_idx_t idx, input graph_pkg::degree_t degree,
		input mem_pkg::addr_t base);
		wait_ready();
		cur_base = base;
		predict_vertex(vid, idx, degree, base);
		vertex_valid     = 1'b1;
		vertex_id        = vid;
		vertex_edges_idx = idx;
		vertex_degree    = degree;
		edges_base       = base;
		@(posedge clock);
		#drive_delay;
		vertex_valid = 1'b0;
	endtask

	initial begin : main
		int cycles;
		int start;
		vertex_valid     = 1'b0;
		vertex_id        = '0;
		vertex_edges_idx = '0;
		vertex_degree    = '0;
		edges_base       = '0;
		cycles           = 0;
		while (!rstn) begin
			@(posedge clock);
			#drive_delay;
			cycles++;
			if (cycles > wait_limit) begin
				$display("ERROR %s: reset never released", test_name);
				abort_run();
			end
		end
		expect_equal("vertex_ready", 1, vertex_ready);
		expect_equal("edge_empty", 1, edge_empty);
		expect_equal("read_request", 0, read_request);
		expect_equal("read_cmd_valid", 0, read_cmd_valid);
		expect_equal("edge_valid", 0, edge_valid);

		test_name      = "aligned";
		consume_enable = 1'b1;
		start          = cmds_seen;
		run_vertex(16'h0011, 24'd16, 16'd8, 32'h0001_0000);
		wait_drained();
		expect_equal("command count", 1, cmds_seen - start);

		test_name = "misaligned";
		start     = cmds_seen;
		run_vertex(16'h0022, 24'd5, 16'd10, 32'h0002_0040);
		wait_drained();
		expect_equal("command count", 2, cmds_seen - start);

		// Two lines fill the edge queue, then issue must stop
		test_name      = "back_pressure";
		consume_enable = 1'b0;
		start          = cmds_seen;
		run_vertex(16'h0033, 24'd64, 16'd40, 32'h0003_0000);
		wait_commands(start + 2);
		repeat (40) @(posedge clock);
		#drive_delay;
		expect_equal("stalled command count", 2, cmds_seen - start);
		expect_equal("stalled read_request", 0, read_request);
		consume_enable = 1'b1;
		wait_drained();
		expect_equal("command count", 5, cmds_seen - start);

		test_name = "random";
		for (int v = 0; v < 20; v++) begin
			run_vertex(graph_pkg::vertex_id_t'(16'h0100 + v),
				graph_pkg::edge_idx_t'({$random(seed)} % 1048576),
				graph_pkg::degree_t'(1 + {$random(seed)} % 40),
				mem_pkg::addr_t'({$random(seed)} & 32'h0fff_ffe0));
		end
		wait_drained();
		expect_equal("read_request", 0, read_request);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: sim.f
mem_pkg.sv
graph_pkg.sv
edge_chunk_if.sv
job_fifo.sv
edge_burst_counter.sv
edge_line_shifter.sv
edge_job_fsm.sv
edge_job_control.sv
tb_clock_gen.sv
tb_edge_job_control.sv

// File: Makefile
TOP = tb_edge_job_control

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
